// ==== flist.f ====
+incdir+.
cnn_bus_pkg.sv
cnn_load_pkg.sv
bus_write_if.sv
store_loader.sv
load_controller.sv
ctrl_regs.sv
param_buffer.sv
buffer_bank.sv
cnn_load_top.sv
cnn_load_asserts.sv
tb_cnn_load.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_cnn_load
RTL_TOP    := cnn_load_top
FLIST      := flist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_cnn_load.sv ====
`timescale 1ns/1ns
`include "cnn_settings.svh"

module tb_cnn_load;

	localparam int RAND_SEED      = 2083;
	// loads, sweeps and register tests come to roughly 13500 cycles
	localparam int TIMEOUT_CYCLES = 20000;
	// stimulus shaping, in percent
	localparam int GAP_PCT        = 40;
	localparam int LONE_PCT       = 10;

	logic                   clk;
	logic                   rst;
	logic [31:0]            awaddr;
	logic                   awvalid;
	logic [31:0]            wdata;
	logic                   wvalid;
	logic                   calc_done;
	logic [1:0]             rd_sel;
	logic [`CNN_ADDR_W-1:0] rd_addr;
	logic [`CNN_WORD_W-1:0] rd_data;
	logic                   pixel_done;
	logic                   weight_done;
	logic                   bias_done;
	logic                   start;
	logic [1:0]             cmd;
	logic                   irq;
	logic [2:0]             done_flags;

	// reference model state
	logic [`CNN_WORD_W-1:0] pix_model [`CNN_PIXEL_NUM];
	logic [`CNN_WORD_W-1:0] wgt_model [`CNN_WEIGHT_NUM];
	logic [`CNN_WORD_W-1:0] bias_model [`CNN_BIAS_NUM];
	int                     pix_count = 0;
	int                     wgt_count = 0;
	int                     bias_count = 0;
	logic [1:0]             cmd_model = 2'd0;
	logic                   irq_model = 1'b0;
	logic [`CNN_WORD_W-1:0] rd_model = '0;
	logic                   rd_known = 1'b0;

	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int test_count = 0;
	int test_base = 0;

	assign done_flags = {bias_done, weight_done, pixel_done};

	cnn_load_top cnn_load_top_inst (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic bit roll(input int pct);
		return $urandom_range(99) < pct;
	endfunction

	function automatic int fill_count(input logic [1:0] sel);
		case (sel)
			cnn_bus_pkg::REGION_PIXEL:  return pix_count;
			cnn_bus_pkg::REGION_WEIGHT: return wgt_count;
			cnn_bus_pkg::REGION_BIAS:   return bias_count;
			default:                    return 0;
		endcase
	endfunction

	function automatic logic [`CNN_WORD_W-1:0] stored_word(input logic [1:0] sel, input int idx);
		case (sel)
			cnn_bus_pkg::REGION_PIXEL:  return pix_model[idx];
			cnn_bus_pkg::REGION_WEIGHT: return wgt_model[idx];
			cnn_bus_pkg::REGION_BIAS:   return bias_model[idx];
			default:                    return '0;
		endcase
	endfunction

	task automatic report_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("ERR %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cycles);
		errors++;
	endtask

	// applies the inputs the DUT sampled at this edge
	task automatic update_model();
		logic        accept;
		logic [15:0] page;
		accept = awvalid && wvalid;
		page = awaddr[31:16];
		// registered read returns the word from before this edge's write
		rd_known = (rd_sel == 2'd0) || (int'(rd_addr) < fill_count(rd_sel));
		rd_model = rd_known ? stored_word(rd_sel, int'(rd_addr)) : '0;
		if (accept && page == `CNN_PIXEL_PAGE && pix_count < `CNN_PIXEL_NUM)
		begin
			pix_model[pix_count] = wdata[15:0];
			pix_count++;
		end
		if (accept && page == `CNN_WEIGHT_PAGE && wgt_count < `CNN_WEIGHT_NUM)
		begin
			wgt_model[wgt_count] = wdata[15:0];
			wgt_count++;
		end
		if (accept && page == `CNN_BIAS_PAGE && bias_count < `CNN_BIAS_NUM)
		begin
			bias_model[bias_count] = wdata[15:0];
			bias_count++;
		end
		// strobe cycle clears the register, a write landing in it is lost
		if (cmd_model != 2'd0)
			cmd_model = 2'd0;
		else if (accept && awaddr == `CNN_IMG_SET_ADDR)
			cmd_model = wdata[1:0];
		if (calc_done)
			irq_model = 1'b1;
		else if (accept && awaddr == `CNN_IRQ_ADDR)
			irq_model = 1'b0;
	endtask

	task automatic check_outputs();
		checks += 6;
		assert (pixel_done === (pix_count == `CNN_PIXEL_NUM))
		else report_value("pixel_done", 32'(pixel_done), 32'(pix_count == `CNN_PIXEL_NUM));
		assert (weight_done === (wgt_count == `CNN_WEIGHT_NUM))
		else report_value("weight_done", 32'(weight_done), 32'(wgt_count == `CNN_WEIGHT_NUM));
		assert (bias_done === (bias_count == `CNN_BIAS_NUM))
		else report_value("bias_done", 32'(bias_done), 32'(bias_count == `CNN_BIAS_NUM));
		assert (start === (cmd_model != 2'd0))
		else report_value("start", 32'(start), 32'(cmd_model != 2'd0));
		assert (cmd === cmd_model)
		else report_value("cmd", 32'(cmd), 32'(cmd_model));
		assert (irq === irq_model)
		else report_value("irq", 32'(irq), 32'(irq_model));
		if (rd_known)
		begin
			checks++;
			assert (rd_data === rd_model)
			else report_value("rd_data", 32'(rd_data), 32'(rd_model));
		end
	endtask

	task automatic drive_cycle(input logic [31:0] a, input logic av, input logic [31:0] d,
		input logic wv, input logic cd, input logic [1:0] rs, input logic [15:0] ra);
		@(posedge clk);
		update_model();
		awaddr    <= a;
		awvalid   <= av;
		wdata     <= d;
		wvalid    <= wv;
		calc_done <= cd;
		rd_sel    <= rs;
		rd_addr   <= ra;
		@(negedge clk);
		check_outputs();
	endtask

	task automatic idle_cycle();
		drive_cycle('0, 1'b0, '0, 1'b0, 1'b0, 2'd0, '0);
	endtask

	task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
		logic lone;
		if (roll(GAP_PCT))
			idle_cycle();
		// one valid alone is no write
		if (roll(LONE_PCT))
		begin
			lone = roll(50);
			drive_cycle(a, lone, $urandom, !lone, 1'b0, 2'd0, '0);
		end
		drive_cycle(a, 1'b1, d, 1'b1, 1'b0, 2'd0, '0);
	endtask

	task automatic readback_sweep(input logic [1:0] sel, input int depth);
		for (int i = 0; i < depth; i++)
			drive_cycle('0, 1'b0, '0, 1'b0, 1'b0, sel, 16'(i));
		idle_cycle();
	endtask

	task automatic wait_flag(input string name, input int which);
		int n;
		n = 0;
		while (done_flags[which] !== 1'b1 && n < 8)
		begin
			idle_cycle();
			n++;
		end
		if (done_flags[which] !== 1'b1)
		begin
			$display("%s never rose after its buffer was filled", name);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		test_count++;
		$display("test %0d %s: %0d errors", test_count, name, errors - test_base);
		test_base = errors;
	endtask

	initial
	begin
		int pick;
		void'($urandom(RAND_SEED));
		rst       = 1'b1;
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wvalid    = 1'b0;
		calc_done = 1'b0;
		rd_sel    = 2'd0;
		rd_addr   = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// bias writes scattered among the weights
		while (wgt_count < `CNN_WEIGHT_NUM || bias_count < `CNN_BIAS_NUM)
		begin
			if (bias_count < `CNN_BIAS_NUM && (wgt_count == `CNN_WEIGHT_NUM || roll(4)))
				bus_write({`CNN_BIAS_PAGE, 16'($urandom)}, $urandom);
			else
				bus_write({`CNN_WEIGHT_PAGE, 16'($urandom)}, $urandom);
		end
		wait_flag("weight_done", 1);
		wait_flag("bias_done", 2);
		readback_sweep(2'(cnn_bus_pkg::REGION_WEIGHT), `CNN_WEIGHT_NUM);
		readback_sweep(2'(cnn_bus_pkg::REGION_BIAS), `CNN_BIAS_NUM);
		finish_test("weight and bias load");

		while (pix_count < `CNN_PIXEL_NUM)
		begin
			pick = int'($urandom_range(9));
			if (pick == 0)
				bus_write({`CNN_WEIGHT_PAGE, 16'($urandom)}, $urandom);
			else if (pick == 1)
				bus_write({`CNN_BIAS_PAGE, 16'($urandom)}, $urandom);
			else
				bus_write({`CNN_PIXEL_PAGE, 16'($urandom)}, $urandom);
		end
		wait_flag("pixel_done", 0);
		readback_sweep(2'(cnn_bus_pkg::REGION_PIXEL), `CNN_PIXEL_NUM);
		finish_test("pixel load");

		// full windows and addresses outside the map
		for (int i = 0; i < 120; i++)
		begin
			pick = int'($urandom_range(3));
			case (pick)
				0:       bus_write({`CNN_PIXEL_PAGE, 16'($urandom)}, $urandom);
				1:       bus_write({`CNN_WEIGHT_PAGE, 16'($urandom)}, $urandom);
				2:       bus_write({`CNN_BIAS_PAGE, 16'($urandom)}, $urandom);
				default: bus_write({4'h1, 28'($urandom)}, $urandom);
			endcase
		end
		readback_sweep(2'(cnn_bus_pkg::REGION_WEIGHT), `CNN_WEIGHT_NUM);
		readback_sweep(2'(cnn_bus_pkg::REGION_BIAS), `CNN_BIAS_NUM);
		readback_sweep(2'(cnn_bus_pkg::REGION_PIXEL), `CNN_PIXEL_NUM);
		finish_test("ignored writes");

		for (int i = 0; i < 40; i++)
		begin
			bus_write(`CNN_IMG_SET_ADDR, $urandom);
			repeat ($urandom_range(2)) idle_cycle();
		end
		idle_cycle();
		finish_test("image-set command");

		// 0 done pulse, 1 cpu clear, 2 both in one cycle
		for (int i = 0; i < 40; i++)
		begin
			pick = int'($urandom_range(2));
			drive_cycle((pick != 0) ? `CNN_IRQ_ADDR : 32'h0, pick != 0, $urandom,
				pick != 0, pick != 1, 2'd0, '0);
			idle_cycle();
		end
		finish_test("interrupt");

		idle_cycle();
		$display("summary: %0d tests, %0d checks, %0d errors", test_count, checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== cnn_load_asserts.sv ====
`timescale 1ns/1ns

module cnn_load_asserts #(
	parameter bit CHECK_START = 1'b1,
	parameter bit CHECK_LOAD  = 1'b1
) (
	input logic       clk,
	input logic       rst,
	input logic       start,
	input logic [2:0] done_flags,
	input logic [2:0] we_flags
);

	generate
		if (CHECK_START)
		begin : g_start
			// command strobe lasts one cycle
			start_pulse: assert property (@(posedge clk) disable iff (rst) start |=> !start)
				else $error("start stayed high for two cycles");
		end

		if (CHECK_LOAD)
		begin : g_load
			// done flags are sticky until reset
			pixel_done_held: assert property (@(posedge clk) disable iff (rst)
				done_flags[0] |=> done_flags[0])
				else $error("pixel done flag fell");
			weight_done_held: assert property (@(posedge clk) disable iff (rst)
				done_flags[1] |=> done_flags[1])
				else $error("weight done flag fell");
			bias_done_held: assert property (@(posedge clk) disable iff (rst)
				done_flags[2] |=> done_flags[2])
				else $error("bias done flag fell");

			// a write reaches one buffer at most
			single_write: assert property (@(posedge clk) disable iff (rst) $onehot0(we_flags))
				else $error("more than one buffer write enable high");
		end
	endgenerate

endmodule

bind ctrl_regs cnn_load_asserts #(
	.CHECK_START (1'b1),
	.CHECK_LOAD  (1'b0)
) ctrl_regs_checks (
	.clk        (clk),
	.rst        (rst),
	.start      (start),
	.done_flags (3'b000),
	.we_flags   (3'b000)
);

bind load_controller cnn_load_asserts #(
	.CHECK_START (1'b0),
	.CHECK_LOAD  (1'b1)
) load_controller_checks (
	.clk        (clk),
	.rst        (rst),
	.start      (1'b0),
	.done_flags ({bias_done, weight_done, pixel_done}),
	.we_flags   ({bias_we, weight_we, pixel_we})
);

// ==== cnn_load_top.sv ====
`timescale 1ns/1ns
`include "cnn_settings.svh"

module cnn_load_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [31:0]            awaddr,
	input  logic                   awvalid,
	input  logic [31:0]            wdata,
	input  logic                   wvalid,
	input  logic                   calc_done,
	input  logic [1:0]             rd_sel,
	input  logic [`CNN_ADDR_W-1:0] rd_addr,
	output logic [`CNN_WORD_W-1:0] rd_data,
	output logic                   pixel_done,
	output logic                   weight_done,
	output logic                   bias_done,
	output logic                   start,
	output logic [1:0]             cmd,
	output logic                   irq
);

	bus_write_if bus_if ();

	logic                   pixel_we;
	logic [`CNN_ADDR_W-1:0] pixel_addr;
	logic [`CNN_WORD_W-1:0] pixel_data;
	logic                   weight_we;
	logic [`CNN_ADDR_W-1:0] weight_addr;
	logic [`CNN_WORD_W-1:0] weight_data;
	logic                   bias_we;
	logic [`CNN_ADDR_W-1:0] bias_addr;
	logic [`CNN_WORD_W-1:0] bias_data;
	cnn_bus_pkg::region_e   rd_region;
	cnn_bus_pkg::img_cmd_e  cmd_value;

	assign bus_if.awaddr  = awaddr;
	assign bus_if.awvalid = awvalid;
	assign bus_if.wdata   = wdata;
	assign bus_if.wvalid  = wvalid;

	// readback select uses the region encoding
	assign rd_region = cnn_bus_pkg::region_e'(rd_sel);
	assign cmd       = cmd_value;

	load_controller load_controller_inst (
		.clk         (clk),
		.rst         (rst),
		.bus         (bus_if.decoder),
		.pixel_we    (pixel_we),
		.pixel_addr  (pixel_addr),
		.pixel_data  (pixel_data),
		.weight_we   (weight_we),
		.weight_addr (weight_addr),
		.weight_data (weight_data),
		.bias_we     (bias_we),
		.bias_addr   (bias_addr),
		.bias_data   (bias_data),
		.pixel_done  (pixel_done),
		.weight_done (weight_done),
		.bias_done   (bias_done)
	);

	ctrl_regs ctrl_regs_inst (
		.clk       (clk),
		.rst       (rst),
		.bus       (bus_if.regs),
		.calc_done (calc_done),
		.start     (start),
		.cmd       (cmd_value),
		.irq       (irq)
	);

	buffer_bank buffer_bank_inst (
		.clk         (clk),
		.rst         (rst),
		.pixel_we    (pixel_we),
		.pixel_addr  (pixel_addr),
		.pixel_data  (pixel_data),
		.weight_we   (weight_we),
		.weight_addr (weight_addr),
		.weight_data (weight_data),
		.bias_we     (bias_we),
		.bias_addr   (bias_addr),
		.bias_data   (bias_data),
		.rd_sel      (rd_region),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data)
	);

endmodule

// ==== buffer_bank.sv ====
`timescale 1ns/1ns
`include "cnn_settings.svh"

module buffer_bank (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   pixel_we,
	input  logic [`CNN_ADDR_W-1:0] pixel_addr,
	input  logic [`CNN_WORD_W-1:0] pixel_data,
	input  logic                   weight_we,
	input  logic [`CNN_ADDR_W-1:0] weight_addr,
	input  logic [`CNN_WORD_W-1:0] weight_data,
	input  logic                   bias_we,
	input  logic [`CNN_ADDR_W-1:0] bias_addr,
	input  logic [`CNN_WORD_W-1:0] bias_data,
	input  cnn_bus_pkg::region_e   rd_sel,
	input  logic [`CNN_ADDR_W-1:0] rd_addr,
	output logic [`CNN_WORD_W-1:0] rd_data
);

	cnn_bus_pkg::region_e   sel_q;
	logic [`CNN_WORD_W-1:0] pixel_q;
	logic [`CNN_WORD_W-1:0] weight_q;
	logic [`CNN_WORD_W-1:0] bias_q;

	param_buffer #(.DEPTH(`CNN_PIXEL_NUM), .WIDTH(`CNN_WORD_W)) pixel_buf (
		.clk (clk), .we (pixel_we), .waddr (pixel_addr), .wdata (pixel_data),
		.raddr (rd_addr), .rdata (pixel_q)
	);

	param_buffer #(.DEPTH(`CNN_WEIGHT_NUM), .WIDTH(`CNN_WORD_W)) weight_buf (
		.clk (clk), .we (weight_we), .waddr (weight_addr), .wdata (weight_data),
		.raddr (rd_addr), .rdata (weight_q)
	);

	param_buffer #(.DEPTH(`CNN_BIAS_NUM), .WIDTH(`CNN_WORD_W)) bias_buf (
		.clk (clk), .we (bias_we), .waddr (bias_addr), .wdata (bias_data),
		.raddr (rd_addr), .rdata (bias_q)
	);

	// select delayed to line up with the registered reads
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			sel_q <= cnn_bus_pkg::REGION_NONE;
		else
			sel_q <= rd_sel;
	end

	always_comb
	begin
		case (sel_q)
			cnn_bus_pkg::REGION_PIXEL:  rd_data = pixel_q;
			cnn_bus_pkg::REGION_WEIGHT: rd_data = weight_q;
			cnn_bus_pkg::REGION_BIAS:   rd_data = bias_q;
			default:                    rd_data = '0;
		endcase
	end

endmodule

// ==== param_buffer.sv ====
`timescale 1ns/1ns
`include "cnn_settings.svh"

module param_buffer #(
	parameter int DEPTH = 8,
	parameter int WIDTH = 16
) (
	input  logic                   clk,
	input  logic                   we,
	input  logic [`CNN_ADDR_W-1:0] waddr,
	input  logic [WIDTH-1:0]       wdata,
	input  logic [`CNN_ADDR_W-1:0] raddr,
	output logic [WIDTH-1:0]       rdata
);

	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge clk)
	begin
		if (we && (waddr < DEPTH))
			mem[waddr[AW-1:0]] <= wdata;
	end

	// reads beyond the depth return zero
	always_ff @(posedge clk)
	begin
		rdata <= (raddr < DEPTH) ? mem[raddr[AW-1:0]] : '0;
	end

endmodule

// ==== ctrl_regs.sv ====
`timescale 1ns/1ns
`include "cnn_settings.svh"

module ctrl_regs (
	input  logic                  clk,
	input  logic                  rst,
	bus_write_if.regs             bus,
	input  logic                  calc_done,
	output logic                  start,
	output cnn_bus_pkg::img_cmd_e cmd,
	output logic                  irq
);

	cnn_bus_pkg::img_cmd_e img_set;
	logic                  img_wr;
	logic                  irq_wr;

	assign img_wr = bus.accept && (bus.awaddr == `CNN_IMG_SET_ADDR);
	assign irq_wr = bus.accept && (bus.awaddr == `CNN_IRQ_ADDR);

	// a nonzero command is live for one cycle only
	assign start = (img_set != cnn_bus_pkg::CMD_NONE);
	assign cmd   = img_set;

	// self-clear comes first, so a write in the strobe cycle is dropped
	// and start can never stretch
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			img_set <= cnn_bus_pkg::CMD_NONE;
		else if (img_set != cnn_bus_pkg::CMD_NONE)
			img_set <= cnn_bus_pkg::CMD_NONE;
		else if (img_wr)
			img_set <= cnn_bus_pkg::img_cmd_e'(bus.wdata[1:0]);
	end

	// datapath done sets, cpu write clears
	// set wins on a tie
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			irq <= 1'b0;
		else if (calc_done)
			irq <= 1'b1;
		else if (irq_wr)
			irq <= 1'b0;
	end

endmodule

// ==== load_controller.sv ====
`timescale 1ns/1ns
`include "cnn_settings.svh"

module load_controller (
	input  logic                   clk,
	input  logic                   rst,
	bus_write_if.decoder           bus,
	output logic                   pixel_we,
	output logic [`CNN_ADDR_W-1:0] pixel_addr,
	output logic [`CNN_WORD_W-1:0] pixel_data,
	output logic                   weight_we,
	output logic [`CNN_ADDR_W-1:0] weight_addr,
	output logic [`CNN_WORD_W-1:0] weight_data,
	output logic                   bias_we,
	output logic [`CNN_ADDR_W-1:0] bias_addr,
	output logic [`CNN_WORD_W-1:0] bias_data,
	output logic                   pixel_done,
	output logic                   weight_done,
	output logic                   bias_done
);

	cnn_bus_pkg::region_e   region;
	logic [`CNN_WORD_W-1:0] word;

	assign word = bus.wdata[`CNN_WORD_W-1:0];

	// window select on the upper address half of an accepted write
	always_comb
	begin
		region = cnn_bus_pkg::REGION_NONE;
		if (bus.accept)
		begin
			case (bus.awaddr[31:16])
				`CNN_PIXEL_PAGE:  region = cnn_bus_pkg::REGION_PIXEL;
				`CNN_WEIGHT_PAGE: region = cnn_bus_pkg::REGION_WEIGHT;
				`CNN_BIAS_PAGE:   region = cnn_bus_pkg::REGION_BIAS;
				default:          region = cnn_bus_pkg::REGION_NONE;
			endcase
		end
	end

	store_loader #(.DEPTH(`CNN_PIXEL_NUM)) pixel_loader (
		.clk   (clk),
		.rst   (rst),
		.hit   (region == cnn_bus_pkg::REGION_PIXEL),
		.data  (word),
		.we    (pixel_we),
		.addr  (pixel_addr),
		.wdata (pixel_data),
		.done  (pixel_done)
	);

	store_loader #(.DEPTH(`CNN_WEIGHT_NUM)) weight_loader (
		.clk   (clk),
		.rst   (rst),
		.hit   (region == cnn_bus_pkg::REGION_WEIGHT),
		.data  (word),
		.we    (weight_we),
		.addr  (weight_addr),
		.wdata (weight_data),
		.done  (weight_done)
	);

	store_loader #(.DEPTH(`CNN_BIAS_NUM)) bias_loader (
		.clk   (clk),
		.rst   (rst),
		.hit   (region == cnn_bus_pkg::REGION_BIAS),
		.data  (word),
		.we    (bias_we),
		.addr  (bias_addr),
		.wdata (bias_data),
		.done  (bias_done)
	);

endmodule

// ==== store_loader.sv ====
`timescale 1ns/1ns
`include "cnn_settings.svh"

module store_loader #(
	parameter int DEPTH = 8
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   hit,
	input  logic [`CNN_WORD_W-1:0] data,
	output logic                   we,
	output logic [`CNN_ADDR_W-1:0] addr,
	output logic [`CNN_WORD_W-1:0] wdata,
	output logic                   done
);

	// address of the final word of the buffer
	localparam logic [`CNN_ADDR_W-1:0] LAST_ADDR = `CNN_ADDR_W'(DEPTH - 1);

	cnn_load_pkg::load_state_e state;
	cnn_load_pkg::load_state_e state_next;
	logic [`CNN_ADDR_W-1:0]    count;

	// full buffer drops further hits
	assign we    = hit && (state != cnn_load_pkg::LOAD_FINISH);
	assign addr  = we ? count : '0;
	assign wdata = we ? data : '0;
	assign done  = (state == cnn_load_pkg::LOAD_FINISH);

	// leave for finish on the word that fills the buffer,
	// so exactly DEPTH words are stored and done follows one cycle later
	always_comb
	begin
		state_next = state;
		case (state)
			cnn_load_pkg::LOAD_IDLE,
			cnn_load_pkg::LOAD_STORE:
			begin
				if (we)
				begin
					if (count == LAST_ADDR)
						state_next = cnn_load_pkg::LOAD_FINISH;
					else
						state_next = cnn_load_pkg::LOAD_STORE;
				end
			end
			cnn_load_pkg::LOAD_FINISH:
			begin
				state_next = cnn_load_pkg::LOAD_FINISH;
			end
			default:
			begin
				state_next = cnn_load_pkg::LOAD_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			state <= cnn_load_pkg::LOAD_IDLE;
		else
			state <= state_next;
	end

	// fill counter, N-th word lands at N-1
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			count <= '0;
		else if (we)
			count <= count + 1'b1;
	end

endmodule

// ==== bus_write_if.sv ====
`timescale 1ns/1ns

interface bus_write_if;

	logic [31:0] awaddr;
	logic        awvalid;
	logic [31:0] wdata;
	logic        wvalid;

	// both valids in one cycle make one write
	logic        accept;

	assign accept = awvalid && wvalid;

	// window decode side
	modport decoder (input awaddr, input wdata, input accept);
	// control register side
	modport regs (input awaddr, input wdata, input accept);

endinterface

// ==== cnn_load_pkg.sv ====
package cnn_load_pkg;

	// per-buffer store FSM
	// finish is terminal until reset
	typedef enum logic [1:0] {
		LOAD_IDLE   = 2'd0,
		LOAD_STORE  = 2'd1,
		LOAD_FINISH = 2'd2
	} load_state_e;

endpackage

// ==== cnn_bus_pkg.sv ====
package cnn_bus_pkg;

	// decoded memory window of an accepted write
	// also the encoding of the readback select
	typedef enum logic [1:0] {
		REGION_NONE   = 2'd0,
		REGION_PIXEL  = 2'd1,
		REGION_WEIGHT = 2'd2,
		REGION_BIAS   = 2'd3
	} region_e;

	// image-set command handed to the datapath
	// only the value is carried here
	typedef enum logic [1:0] {
		CMD_NONE       = 2'd0,
		CMD_RUN_LAYER1 = 2'd1,
		CMD_RUN_ALL    = 2'd2,
		CMD_ABORT      = 2'd3
	} img_cmd_e;

endpackage

// ==== cnn_settings.svh ====
`ifndef CNN_SETTINGS_SVH
`define CNN_SETTINGS_SVH

// control registers, full 32-bit match
`define CNN_IMG_SET_ADDR 32'hd111_0000
`define CNN_IRQ_ADDR     32'hd222_0000

// buffer windows, matched on the upper address half
`define CNN_PIXEL_PAGE   16'hd333
`define CNN_WEIGHT_PAGE  16'hd444
`define CNN_BIAS_PAGE    16'hd555

// layer-1 buffer depths in words
`define CNN_PIXEL_NUM    3072
`define CNN_WEIGHT_NUM   216
`define CNN_BIAS_NUM     8

// stored word and local buffer address widths
`define CNN_WORD_W       16
`define CNN_ADDR_W       16

`endif
